/* verilog/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// address and word
`define IC_ADDR_W       32
`define IC_DATA_W       32

// geometry, 2 ways x 16 sets x 16 bytes
`define IC_WAYS         2
`define IC_SETS         16
`define IC_BLOCK_WORDS  4
`define IC_OFF_BITS     4   // byte offset in block
`define IC_IDX_BITS     4   // log2 of sets
`define IC_TAG_BITS     24  // addr - idx - off
`define IC_BLOCK_W      128 // block_words * data_w

`define IC_LFSR_W       20  // replacement prng

`endif

/* verilog/icache_pkg.sv */
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  // controller states
  typedef enum logic [1:0] {ARMED, FLUSH, FILL, RECOVER} ic_state_e;
  // fill request towards burst unit
  typedef enum logic {CMD_NOP, CMD_READ_WAY} ic_cmd_e;
  // bus side states
  typedef enum logic [1:0] {IDLE, WAIT4BIU, BURST} burst_state_e;

  typedef logic [`IC_ADDR_W-1:0]   addr_t;
  typedef logic [`IC_DATA_W-1:0]   word_t;
  typedef logic [`IC_TAG_BITS-1:0] tag_t;
  typedef logic [`IC_IDX_BITS-1:0] idx_t;
  typedef logic [`IC_BLOCK_W-1:0]  block_t;
  typedef logic [`IC_WAYS-1:0]     way_mask_t; // one-hot

endpackage

`default_nettype wire

/* verilog/icache_ram.sv */
`timescale 1ns/100ps
`default_nettype none

// single port, registered read
module icache_ram #(
  parameter int ABITS = 4,
  parameter int DBITS = 32
) (
  input  wire              clk_i,
  input  wire  [ABITS-1:0] addr_i,
  input  wire              we_i,
  input  wire  [DBITS-1:0] din_i,
  output logic [DBITS-1:0] dout_o
);

  logic [DBITS-1:0] mem [2**ABITS];

  // read returns old contents on a write cycle
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= din_i;
    end
    dout_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

/* verilog/icache_tag_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_tag_array
  import icache_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            flush_clr_i,  // drop all lines
  input  wire idx_t      tag_idx_i,
  input  wire way_mask_t tag_we_i,
  input  wire tag_t      wr_tag_i,
  input  wire tag_t      cmp_tag_i,    // tag of pending request
  output way_mask_t      way_hit_o,
  output logic           cache_hit_o
);

  tag_t                              rd_tag [`IC_WAYS];
  logic [`IC_WAYS-1:0][`IC_SETS-1:0] valid_q;
  idx_t                              idx_q;  // index of the read in flight

  // follows the ram read by one cycle
  always_ff @(posedge clk_i) begin
    idx_q <= tag_idx_i;
  end

  // valid bits in flops so a flush is a single cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_clr_i) begin
      valid_q <= '0;
    end else begin
      for (int w = 0; w < `IC_WAYS; w++) begin
        if (tag_we_i[w]) valid_q[w][tag_idx_i] <= 1'b1;  // line filled
      end
    end
  end

  for (genvar w = 0; w < `IC_WAYS; w++) begin : g_way
    icache_ram #(
      .ABITS(`IC_IDX_BITS),
      .DBITS(`IC_TAG_BITS)
    ) u_tag_ram (
      .clk_i (clk_i),
      .addr_i(tag_idx_i),
      .we_i  (tag_we_i[w]),
      .din_i (wr_tag_i),
      .dout_o(rd_tag[w])
    );

    assign way_hit_o[w] = valid_q[w][idx_q] & (rd_tag[w] == cmp_tag_i);
  end

  assign cache_hit_o = |way_hit_o;

endmodule

`default_nettype wire

/* verilog/icache_data_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_data_array
  import icache_pkg::*;
(
  input  wire                                clk_i,
  input  wire idx_t                          dat_idx_i,
  input  wire way_mask_t                     dat_we_i,     // whole block write
  input  wire block_t                        fill_block_i,
  input  wire way_mask_t                     way_hit_i,
  input  wire [$clog2(`IC_BLOCK_WORDS)-1:0]  word_sel_i,
  output word_t                              hit_word_o
);

  block_t rd_blk  [`IC_WAYS];
  block_t mux_blk [`IC_WAYS];  // running and/or chain

  for (genvar w = 0; w < `IC_WAYS; w++) begin : g_way
    icache_ram #(
      .ABITS(`IC_IDX_BITS),
      .DBITS(`IC_BLOCK_W)
    ) u_dat_ram (
      .clk_i (clk_i),
      .addr_i(dat_idx_i),
      .we_i  (dat_we_i[w]),
      .din_i (fill_block_i),
      .dout_o(rd_blk[w])
    );

    if (w == 0) begin : g_first
      assign mux_blk[w] = rd_blk[w] & {`IC_BLOCK_W{way_hit_i[w]}};
    end else begin : g_next
      assign mux_blk[w] = (rd_blk[w] & {`IC_BLOCK_W{way_hit_i[w]}}) | mux_blk[w-1];
    end
  end

  // pick the word out of the hit block
  assign hit_word_o = mux_blk[`IC_WAYS-1][word_sel_i*`IC_DATA_W +: `IC_DATA_W];

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  wire                                clk_i,
  input  wire                                rst_ni,
  input  wire                                req_i,
  input  wire                                clr_i,      // drop pending request
  input  wire                                flush_i,
  input  wire addr_t                         adr_i,
  input  wire                                cache_hit_i,
  input  wire                                fill_done_i,
  input  wire                                fill_err_i,
  output logic                               ack_o,
  output logic                               err_o,
  output idx_t                               tag_idx_o,
  output idx_t                               dat_idx_o,
  output way_mask_t                          tag_we_o,
  output way_mask_t                          dat_we_o,
  output tag_t                               cmp_tag_o,
  output tag_t                               wr_tag_o,
  output logic [$clog2(`IC_BLOCK_WORDS)-1:0] word_sel_o,
  output logic                               flush_clr_o,
  output ic_cmd_e                            fill_cmd_o,
  output addr_t                              fill_adr_o
);

  ic_state_e             state_q;
  ic_cmd_e               fill_cmd_q;
  logic                  req_pend_q;
  logic                  hold_flush_q;  // flush seen outside ARMED
  addr_t                 req_adr_q;
  addr_t                 fill_adr_q;    // stays put while a new req may arrive
  way_mask_t             fill_way_q;
  logic [`IC_LFSR_W-1:0] lfsr_q;
  idx_t                  cur_idx;
  logic                  flush_go;
  logic                  miss;

  //////////////////////////////
  // request capture
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_pend_q   <= 1'b0;
      hold_flush_q <= 1'b0;
    end else begin
      req_pend_q   <= ~clr_i & (req_i | (req_pend_q & ~ack_o & ~err_o));
      hold_flush_q <= (flush_i | hold_flush_q) & (state_q != FLUSH);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) req_adr_q <= adr_i;
  end

  assign flush_go = flush_i | hold_flush_q;
  assign miss     = (state_q == ARMED) & req_pend_q & ~cache_hit_i & ~clr_i & ~flush_go;

  //////////////////////////////
  // lookup / fill / flush fsm
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ARMED;
      fill_cmd_q <= CMD_NOP;
    end else begin
      case (state_q)
        ARMED: begin
          if (flush_go) begin
            state_q <= FLUSH;
          end else if (miss) begin
            state_q    <= FILL;
            fill_cmd_q <= CMD_READ_WAY;  // burst unit picks this up
          end
        end
        FLUSH:   state_q <= RECOVER;  // valids clear this cycle
        FILL: begin
          if (fill_done_i || fill_err_i) begin
            state_q    <= RECOVER;
            fill_cmd_q <= CMD_NOP;
          end
        end
        default: state_q <= ARMED;    // RECOVER, re-read after write
      endcase
    end
  end

  // xnor lfsr, taps 20 and 17, frozen while filling
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (state_q != FILL) begin
      lfsr_q <= {lfsr_q[`IC_LFSR_W-2:0], lfsr_q[19] ~^ lfsr_q[16]};
    end
  end

  // latch victim and address on miss
  always_ff @(posedge clk_i) begin
    if (miss) begin
      fill_adr_q <= req_adr_q;
      fill_way_q <= way_mask_t'(1) << lfsr_q[0];
    end
  end

  // new request wins over the pending one
  assign cur_idx   = req_i ? adr_i[`IC_OFF_BITS +: `IC_IDX_BITS]
                           : req_adr_q[`IC_OFF_BITS +: `IC_IDX_BITS];
  assign tag_idx_o = (state_q == FILL) ? fill_adr_q[`IC_OFF_BITS +: `IC_IDX_BITS] : cur_idx;
  assign dat_idx_o = tag_idx_o;  // tags and data share the index

  assign tag_we_o    = (state_q == FILL && fill_done_i) ? fill_way_q : '0;  // not on error
  assign dat_we_o    = tag_we_o;
  assign wr_tag_o    = fill_adr_q[`IC_ADDR_W-1 -: `IC_TAG_BITS];
  assign cmp_tag_o   = req_adr_q[`IC_ADDR_W-1 -: `IC_TAG_BITS];
  assign word_sel_o  = req_adr_q[`IC_OFF_BITS-1:$clog2(`IC_DATA_W/8)];
  assign flush_clr_o = (state_q == FLUSH);
  assign fill_cmd_o  = fill_cmd_q;
  assign fill_adr_o  = fill_adr_q;

  assign ack_o = (state_q == ARMED) & req_pend_q & cache_hit_i;
  assign err_o = (state_q == FILL) & req_pend_q & fill_err_i;  // dropped reqs stay silent

endmodule

`default_nettype wire

/* verilog/icache_burst_fill.sv */
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_burst_fill
  import icache_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_ni,
  input  wire ic_cmd_e fill_cmd_i,
  input  wire addr_t   fill_adr_i,     // held by ctrl for the whole fill
  input  wire          biu_stb_ack_i,
  input  wire          biu_ack_i,      // one per beat
  input  wire          biu_err_i,
  input  wire word_t   biu_q_i,
  output logic         biu_stb_o,
  output addr_t        biu_adr_o,
  output logic         fill_done_o,
  output logic         fill_err_o,
  output block_t       fill_block_o
);

  burst_state_e                        state_q;
  logic [$clog2(`IC_BLOCK_WORDS)-1:0] cnt_q;   // beats left minus one
  logic [$clog2(`IC_BLOCK_WORDS)-1:0] beat;
  block_t                             buf_q;
  logic                               beat_ok;

  //////////////////////////////
  // bus fsm
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (fill_cmd_i == CMD_READ_WAY) begin
            state_q <= biu_stb_ack_i ? BURST : WAIT4BIU;
            cnt_q   <= '1;
          end
        end
        WAIT4BIU: if (biu_stb_ack_i) state_q <= BURST;  // stb accepted
        BURST: begin
          if (biu_err_i || (cnt_q == '0 && biu_ack_i)) state_q <= IDLE;
          if (biu_ack_i) cnt_q <= cnt_q - 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign biu_stb_o = (state_q == WAIT4BIU) || (state_q == IDLE && fill_cmd_i == CMD_READ_WAY);
  assign biu_adr_o = {fill_adr_i[`IC_ADDR_W-1:`IC_OFF_BITS], {`IC_OFF_BITS{1'b0}}};

  // beats come in ascending order, counter goes down
  assign beat    = ~cnt_q;
  assign beat_ok = (state_q == BURST) & biu_ack_i;

  // merge current beat so the last word is there with fill_done
  always_comb begin
    fill_block_o = buf_q;
    if (beat_ok) fill_block_o[beat*`IC_DATA_W +: `IC_DATA_W] = biu_q_i;
  end

  always_ff @(posedge clk_i) begin
    if (beat_ok) buf_q <= fill_block_o;
  end

  assign fill_done_o = beat_ok & (cnt_q == '0) & ~biu_err_i;
  assign fill_err_o  = (state_q == BURST) & biu_err_i;

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_top
  import icache_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  // cpu side
  input  wire        req_i,
  input  wire addr_t adr_i,
  input  wire        clr_i,
  input  wire        flush_i,
  output word_t      q_o,
  output logic       ack_o,
  output logic       err_o,
  // bus side
  output logic       biu_stb_o,
  input  wire        biu_stb_ack_i,
  output addr_t      biu_adr_o,
  input  wire        biu_ack_i,
  input  wire        biu_err_i,
  input  wire word_t biu_q_i
);

  ic_cmd_e                            fill_cmd;
  addr_t                              fill_adr;
  idx_t                               tag_idx;
  idx_t                               dat_idx;
  way_mask_t                          tag_we_way;
  way_mask_t                          dat_we_way;
  way_mask_t                          way_hit;
  tag_t                               wr_tag;
  tag_t                               cmp_tag;
  logic [$clog2(`IC_BLOCK_WORDS)-1:0] word_sel;
  logic                               flush_clr;
  logic                               cache_hit;
  logic                               fill_done;
  logic                               fill_err;
  block_t                             fill_block;

  icache_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .clr_i      (clr_i),
    .flush_i    (flush_i),
    .adr_i      (adr_i),
    .cache_hit_i(cache_hit),
    .fill_done_i(fill_done),
    .fill_err_i (fill_err),
    .ack_o      (ack_o),
    .err_o      (err_o),
    .tag_idx_o  (tag_idx),
    .dat_idx_o  (dat_idx),
    .tag_we_o   (tag_we_way),
    .dat_we_o   (dat_we_way),
    .cmp_tag_o  (cmp_tag),
    .wr_tag_o   (wr_tag),
    .word_sel_o (word_sel),
    .flush_clr_o(flush_clr),
    .fill_cmd_o (fill_cmd),
    .fill_adr_o (fill_adr)
  );

  icache_tag_array u_tags (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_clr_i(flush_clr),
    .tag_idx_i  (tag_idx),
    .tag_we_i   (tag_we_way),
    .wr_tag_i   (wr_tag),
    .cmp_tag_i  (cmp_tag),
    .way_hit_o  (way_hit),
    .cache_hit_o(cache_hit)
  );

  icache_data_array u_data (
    .clk_i       (clk_i),
    .dat_idx_i   (dat_idx),
    .dat_we_i    (dat_we_way),
    .fill_block_i(fill_block),
    .way_hit_i   (way_hit),
    .word_sel_i  (word_sel),
    .hit_word_o  (q_o)
  );

  icache_burst_fill u_burst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fill_cmd_i   (fill_cmd),
    .fill_adr_i   (fill_adr),
    .biu_stb_ack_i(biu_stb_ack_i),
    .biu_ack_i    (biu_ack_i),
    .biu_err_i    (biu_err_i),
    .biu_q_i      (biu_q_i),
    .biu_stb_o    (biu_stb_o),
    .biu_adr_o    (biu_adr_o),
    .fill_done_o  (fill_done),
    .fill_err_o   (fill_err),
    .fill_block_o (fill_block)
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

// 8 ns clock, reset low for 8 cycles
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_no = 1'b1;  // released off the edge
  end

endmodule

`default_nettype wire

/* verif/tb_bus_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

// bus slave, word = address ^ 5a5a0000
module tb_bus_mem
  import icache_pkg::*;
(
  input  wire        clk_i,
  input  wire        stb_i,
  input  wire addr_t adr_i,
  input  wire        arm_en_i,   // error on beat 1 of this block
  input  wire addr_t arm_adr_i,
  output logic       stb_ack_o,
  output logic       ack_o,
  output logic       err_o,
  output word_t      q_o
);

  int    seed = 32'h1feead45;
  addr_t blk;
  logic  bad;

  // every output change lands 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic stall();
    int d;
    d = $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
    repeat (d) next_cycle();
  endtask

  initial begin
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    err_o     = 1'b0;
    q_o       = '0;
    forever begin
      next_cycle();
      if (stb_i) begin
        blk = adr_i;
        bad = arm_en_i &&
              (arm_adr_i[`IC_ADDR_W-1:`IC_OFF_BITS] == adr_i[`IC_ADDR_W-1:`IC_OFF_BITS]);
        stall();           // strobe stays high meanwhile
        stb_ack_o = 1'b1;
        next_cycle();
        stb_ack_o = 1'b0;
        // beats in ascending order
        for (int b = 0; b < `IC_BLOCK_WORDS; b++) begin
          stall();
          if (bad && b == 1) begin
            err_o = 1'b1;  // ends the burst
          end else begin
            ack_o = 1'b1;
            q_o   = (blk + 32'(4 * b)) ^ 32'h5a5a0000;
          end
          next_cycle();
          ack_o = 1'b0;
          err_o = 1'b0;
          if (bad && b == 1) break;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tb_icache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache
  import icache_pkg::*;
();

  localparam int TIMEOUT = 100;  // cycles per request

  logic  clk, rst_n;
  logic  req, clr, flush, ack, err;
  addr_t adr, biu_adr, arm_adr;
  word_t q, biu_q;
  logic  biu_stb, biu_stb_ack, biu_ack, biu_err, arm_en;
  int    errors = 0;
  int    checks = 0;
  int    test_errs = 0;
  int    seed = 32'h1feead45;
  string tname = "reset";
  bit    timeout_hit = 1'b0;

  tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  tb_bus_mem u_mem (
    .clk_i    (clk),
    .stb_i    (biu_stb),
    .adr_i    (biu_adr),
    .arm_en_i (arm_en),
    .arm_adr_i(arm_adr),
    .stb_ack_o(biu_stb_ack),
    .ack_o    (biu_ack),
    .err_o    (biu_err),
    .q_o      (biu_q)
  );

  icache_top UUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .adr_i        (adr),
    .clr_i        (clr),
    .flush_i      (flush),
    .q_o          (q),
    .ack_o        (ack),
    .err_o        (err),
    .biu_stb_o    (biu_stb),
    .biu_stb_ack_i(biu_stb_ack),
    .biu_adr_o    (biu_adr),
    .biu_ack_i    (biu_ack),
    .biu_err_i    (biu_err),
    .biu_q_i      (biu_q)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic word_t expect_word(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a0000;  // what the bus holds there
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;  // drive point
  endtask

  task automatic check_val(input string what, input word_t exp, input word_t act);
    checks++;
    assert (exp === act) else begin
      $display("ERR %s %s expected %h actual %h", tname, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s: %s", tname, msg);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    tname     = name;
    test_errs = errors;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", tname, errors - test_errs);
  endtask

  // one request that clr_at > 0 drops in that cycle
  task automatic do_req(input addr_t a, input int clr_at, output int lat, output int stb_at,
                        output bit acked, output bit erred, output word_t data);
    int n;
    bit done;
    n      = 0;
    done   = 1'b0;
    lat    = 0;
    stb_at = 0;
    acked  = 1'b0;
    erred  = 1'b0;
    data   = '0;
    req    = 1'b1;
    adr    = a;
    next_cycle();
    req = 1'b0;
    while (!done && n < TIMEOUT) begin
      n++;
      clr = (n == clr_at);
      @(negedge clk);  // outputs settled mid cycle
      if (biu_stb) begin
        if (stb_at == 0) stb_at = n;  // first strobe cycle
        check_val("strobe address", a & 32'hffff_fff0, biu_adr);
      end
      if (ack || err) begin
        check_true(!(ack && err), "ack and err in the same cycle");
        acked = ack;
        erred = err;
        data  = q;
        lat   = n;
        done  = 1'b1;
      end else if (clr) begin
        done = 1'b1;   // dropped
      end
      next_cycle();
    end
    clr = 1'b0;
    if (!done) timeout_hit = 1'b1;
  endtask

  // nothing may complete while no request is pending
  task automatic idle_watch(input int cycles, input bit no_stb);
    repeat (cycles) begin
      @(negedge clk);
      check_true(!ack && !err, "ack or err with no request pending");
      if (no_stb) check_true(!biu_stb, "bus strobe with no miss pending");
      next_cycle();
    end
  endtask

  always @(posedge timeout_hit) begin
    $display("timeout in test %s, the cache never answered", tname);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // tests
  //////////////////////////////
  initial begin
    int    lat, stb_at, hits, n, k, clr_at;
    bit    acked, erred;
    word_t data;
    addr_t a;
    addr_t blk [3];
    addr_t rnd_blk [8];
    req     = 1'b0;
    adr     = '0;
    clr     = 1'b0;
    flush   = 1'b0;
    arm_en  = 1'b0;
    arm_adr = '0;
    n = 0;
    while (!rst_n && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) timeout_hit = 1'b1;
    #1;

    start_test("reset");
    idle_watch(2, 1'b1);  // ack err and stb stay low
    end_test();

    start_test("miss_fill");
    a = 32'h0000_1108;
    do_req(a, 0, lat, stb_at, acked, erred, data);
    check_val("strobe delay", 32'd2, word_t'(stb_at));
    check_true(acked, "miss did not end with ack");
    check_val("data", expect_word(a), data);
    end_test();

    start_test("hit_latency");
    for (int w = 0; w < `IC_BLOCK_WORDS; w++) begin
      a = 32'h0000_1100 + 32'(4 * w);  // same block as above
      do_req(a, 0, lat, stb_at, acked, erred, data);
      check_val("hit latency", 32'd1, word_t'(lat));
      check_val("data", expect_word(a), data);
      idle_watch(2, 1'b1);  // a hit never goes to the bus
    end
    end_test();

    start_test("replace");
    blk[0] = 32'h0001_0030;  // all in set 3
    blk[1] = 32'h0002_0030;
    blk[2] = 32'h0003_0030;
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 3; i++) begin
        a = blk[i] + 32'(4 * r);
        do_req(a, 0, lat, stb_at, acked, erred, data);
        check_true(acked, "request did not end with ack");
        check_val("data", expect_word(a), data);
        check_true((lat == 1 && stb_at == 0) || stb_at != 0,
                   "request neither hit in one cycle nor went to the bus");
      end
    end
    // probes dropped in cycle 1 start no fill
    hits = 0;
    for (int i = 0; i < 3; i++) begin
      do_req(blk[i], 1, lat, stb_at, acked, erred, data);
      if (acked) hits++;
      idle_watch(3, 1'b1);  // no strobe from a dropped miss
    end
    check_true(hits <= 2, "three blocks resident in a two-way set");
    end_test();

    start_test("flush");
    a = blk[2] + 32'h8;
    do_req(a, 0, lat, stb_at, acked, erred, data);  // make it resident
    check_val("data", expect_word(a), data);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    idle_watch(3, 1'b1);  // FLUSH then RECOVER
    do_req(a, 0, lat, stb_at, acked, erred, data);
    check_true(stb_at != 0, "no refetch after flush");
    check_true(acked, "refetch did not end with ack");
    check_val("data", expect_word(a), data);
    end_test();

    start_test("bus_error");
    a       = 32'h0004_0054;
    arm_adr = a & 32'hffff_fff0;
    arm_en  = 1'b1;
    do_req(a, 0, lat, stb_at, acked, erred, data);
    check_true(erred, "armed block did not end with err");
    check_true(!acked, "ack on a failed fill");
    idle_watch(6, 1'b0);
    arm_en = 1'b0;
    do_req(a, 0, lat, stb_at, acked, erred, data);
    check_true(stb_at != 0, "failed block was left in the cache");
    check_true(acked, "retry did not end with ack");
    check_val("data", expect_word(a), data);
    end_test();

    start_test("random");
    for (int i = 0; i < 8; i++) begin
      rnd_blk[i] = addr_t'($random(seed)) & 32'hffff_fff0;
    end
    for (int i = 0; i < 200; i++) begin
      k      = $unsigned($random(seed)) % 8;
      a      = rnd_blk[k] + 32'(4 * ($unsigned($random(seed)) % 4));
      clr_at = 0;
      if ($unsigned($random(seed)) % 8 == 0) clr_at = 1 + $unsigned($random(seed)) % 6;
      do_req(a, clr_at, lat, stb_at, acked, erred, data);
      if (acked) begin
        check_val("data", expect_word(a), data);
      end else if (erred) begin
        check_true(1'b0, "err without a bus error");
      end else begin
        idle_watch(30, 1'b0);  // let a dropped fill drain
      end
    end
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_ram.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_ctrl.sv
verilog/icache_burst_fill.sv
verilog/icache_top.sv
verif/tb_clk_gen.sv
verif/tb_bus_mem.sv
verif/tb_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the icache testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_icache -f build.f -o sim_icache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/sim_icache)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
